//--- compile.f
arb_pkg.sv
mem_pkg.sv
mem_if.sv
client_port.sv
lru_arbiter4.sv
mem_scheduler.sv
scratch_ram.sv
shared_ram_top.sv
shared_ram_asserts.sv
tb_clock.sv
tb_top.sv

//--- Makefile
# Verilator build and run for the shared scratch RAM testbench

SIM = obj_dir/Vtb_top

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f compile.f

# Status comes from grep, so a missing pass line fails the target
run: compile
	./$(SIM) +verilator+error+limit+1000 | tee /dev/stderr | grep -q "^Simulation passed$$"

clean:
	rm -rf obj_dir

//--- tb_top.sv
// Testbench top for the shared scratch RAM
// Solo write and read-back per client, then four-client random traffic
// Closing line with assertion and timeout counts

`timescale 1ns/1ns

module tb_top;
	import arb_pkg::*;
	import mem_pkg::*;

	logic clk;
	logic reset;
	logic req [NUM_CLIENTS];
	logic we [NUM_CLIENTS];
	logic [ADDR_W-1:0] addr [NUM_CLIENTS];
	logic [DATA_W-1:0] wdata [NUM_CLIENTS];
	logic ack [NUM_CLIENTS];
	logic [DATA_W-1:0] rdata [NUM_CLIENTS];
	int timeouts = 0;
	int assert_errors;

	tb_clock clkgen0 (
		.clk_o(clk),
		.reset_o(reset)
	);

	shared_ram_top dut0 (
		.clk(clk),
		.reset_i(reset),
		.req_i(req),
		.we_i(we),
		.addr_i(addr),
		.wdata_i(wdata),
		.ack_o(ack),
		.rdata_o(rdata)
	);

	task automatic wait_reset_done();
		int cycles;
		cycles = 0;
		do
		begin
			@(posedge clk);
			cycles++;
		end
		while (reset !== 1'b0 && cycles < 20);
		if (reset !== 1'b0)
		begin
			$display("Timeout: reset still asserted after 20 cycles");
			timeouts++;
		end
	endtask

	// Level is checked at each rising edge, before the DUT updates
	task automatic await_ack(input int n, input logic level);
		int cycles;
		cycles = 0;
		do
		begin
			@(posedge clk);
			cycles++;
		end
		while (ack[n] !== level && cycles < 20);
		if (ack[n] !== level)
		begin
			$display("Timeout: ack_o[%0d] did not go to %0b within 20 cycles", n, level);
			timeouts++;
		end
	endtask

	// One full four-phase transfer
	task automatic access(input int n, input logic wr, input logic [ADDR_W-1:0] a,
		input logic [DATA_W-1:0] d);
		@(posedge clk);
		req[n] <= 1'b1;
		we[n] <= wr;
		addr[n] <= a;
		wdata[n] <= d;
		await_ack(n, 1'b1);
		req[n] <= 1'b0;
		await_ack(n, 1'b0);
	endtask

	// Small address range so clients collide
	task automatic random_traffic(input int n, input int count);
		for (int i = 0; i < count; i++)
			access(n, 1'($urandom_range(1)), ADDR_W'($urandom_range(7)), DATA_W'($urandom));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		logic [ADDR_W-1:0] a;
		// Seed the generator once for the whole run
		void'($urandom(32'h1f85));
		for (int n = 0; n < NUM_CLIENTS; n++)
		begin
			req[n] = 1'b0;
			we[n] = 1'b0;
			addr[n] = '0;
			wdata[n] = '0;
		end
		wait_reset_done();

		// Each client alone, write then read back
		for (int n = 0; n < NUM_CLIENTS; n++)
		begin
			a = ADDR_W'($urandom);
			access(n, 1'b1, a, DATA_W'($urandom));
			access(n, 1'b0, a, '0);
		end

		// All four back to back
		fork
			random_traffic(0, 16);
			random_traffic(1, 16);
			random_traffic(2, 16);
			random_traffic(3, 16);
		join

		repeat (4)
			@(posedge clk);
		assert_errors = dut0.chk0.fail_count;
		$display("Error counts: %0d assertion, %0d timeout", assert_errors, timeouts);
		if (assert_errors == 0 && timeouts == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- tb_clock.sv
// Testbench clock and reset source
// 40 ns clock, reset high for the first 8 rising edges

`timescale 1ns/1ns

module tb_clock (
	output logic clk_o,
	output logic reset_o
);

	initial
	begin
		clk_o = 1'b0;
		forever
			#20 clk_o = ~clk_o;
	end

	initial
	begin
		reset_o = 1'b1;
		repeat (8)
			@(posedge clk_o);
		reset_o <= 1'b0;
	end

endmodule

//--- shared_ram_asserts.sv
// Bound checker for the shared scratch RAM top level
// Shadow memory of acked writes and per-client request tracking
// Handshake, latency, data and reset assertions

`timescale 1ns/1ns

module shared_ram_asserts (
	input  logic clk,
	input  logic reset_i,
	input  logic req_i [arb_pkg::NUM_CLIENTS],
	input  logic we_i [arb_pkg::NUM_CLIENTS],
	input  logic [mem_pkg::ADDR_W-1:0] addr_i [arb_pkg::NUM_CLIENTS],
	input  logic [mem_pkg::DATA_W-1:0] wdata_i [arb_pkg::NUM_CLIENTS],
	input  logic ack_i [arb_pkg::NUM_CLIENTS],
	input  logic [mem_pkg::DATA_W-1:0] rdata_i [arb_pkg::NUM_CLIENTS]
);
	import arb_pkg::*;
	import mem_pkg::*;

	logic [DATA_W-1:0] shadow [RAM_DEPTH];
	logic [RAM_DEPTH-1:0] written;
	logic [NUM_CLIENTS-1:0] start;
	logic [NUM_CLIENTS-1:0] active;
	logic [NUM_CLIENTS-1:0] solo;
	logic [NUM_CLIENTS-1:0] ack_q;
	logic [7:0] lat [NUM_CLIENTS];
	int fail_count = 0;

	function automatic logic [NUM_CLIENTS-1:0] client_bit(input int n);
		return NUM_CLIENTS'(1) << n;
	endfunction

	// A request opens when the port is idle and req is seen
	always_comb
	begin
		for (int n = 0; n < NUM_CLIENTS; n++)
			start[n] = req_i[n] && !ack_i[n] && !active[n];
	end

	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			active <= '0;
			solo <= '0;
			ack_q <= '0;
			written <= '0;
		end
		else
		begin
			for (int n = 0; n < NUM_CLIENTS; n++)
			begin
				ack_q[n] <= ack_i[n];
				if (start[n])
				begin
					active[n] <= 1'b1;
					lat[n] <= '0;
					// Alone only if no other client is in flight or starting
					solo[n] <= ((active | start) & ~client_bit(n)) == '0;
				end
				else if (active[n])
				begin
					lat[n] <= lat[n] + 8'd1;
					if (ack_i[n])
						active[n] <= 1'b0;
					if ((start & ~client_bit(n)) != '0)
						solo[n] <= 1'b0;
				end
				// Ack order matches issue order, so the shadow follows the RAM
				if (ack_i[n] && !ack_q[n] && we_i[n])
				begin
					shadow[addr_i[n]] <= wdata_i[n];
					written[addr_i[n]] <= 1'b1;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Per-client properties
	////////////////////////////////////////////////////////////////////////////

	for (genvar n = 0; n < NUM_CLIENTS; n++)
	begin : g_client
		assert property (@(posedge clk) disable iff (reset_i) ack_i[n] |-> $past(req_i[n]))
		else
		begin
			fail_count++;
			$error("Client %0d ack_o high without req_i at the previous edge", n);
		end

		// Ack holds while req is high and falls one edge after req is seen low
		assert property (@(posedge clk) disable iff (reset_i)
			ack_i[n] |=> ack_i[n] == $past(req_i[n]))
		else
		begin
			fail_count++;
			$error("ERR %0t ack_o[%0d] got %0b expected %0b", $time, n, ack_i[n],
				!ack_i[n]);
		end

		// Three edges from capture to ack when nobody else is around
		assert property (@(posedge clk) disable iff (reset_i)
			($rose(ack_i[n]) && solo[n]) |-> lat[n] == 8'd3)
		else
		begin
			fail_count++;
			$error("Client %0d alone took %0d edges to ack instead of 3", n, lat[n]);
		end

		// Tree bound of four grants plus the pipeline
		assert property (@(posedge clk) disable iff (reset_i)
			$rose(ack_i[n]) |-> lat[n] <= 8'd6)
		else
		begin
			fail_count++;
			$error("Client %0d waited %0d edges for ack, more than 6", n, lat[n]);
		end

		assert property (@(posedge clk) disable iff (reset_i)
			($rose(ack_i[n]) && !we_i[n] && written[addr_i[n]])
			|-> rdata_i[n] == shadow[addr_i[n]])
		else
		begin
			fail_count++;
			$error("ERR %0t rdata_o[%0d] got %h expected %h", $time, n, rdata_i[n],
				shadow[addr_i[n]]);
		end

		assert property (@(posedge clk) reset_i |=> !ack_i[n])
		else
		begin
			fail_count++;
			$error("ERR %0t ack_o[%0d] got 1 expected 0 around reset", $time, n);
		end
	end

endmodule

bind shared_ram_top shared_ram_asserts chk0 (
	.clk(clk),
	.reset_i(reset_i),
	.req_i(req_i),
	.we_i(we_i),
	.addr_i(addr_i),
	.wdata_i(wdata_i),
	.ack_i(ack_o),
	.rdata_i(rdata_o)
);

//--- shared_ram_top.sv
// Shared scratch RAM top level
// Four client ports, the scheduler and the RAM, with plain per-client ports

`timescale 1ns/1ns

module shared_ram_top (
	input  logic clk,
	input  logic reset_i,
	input  logic req_i [arb_pkg::NUM_CLIENTS],
	input  logic we_i [arb_pkg::NUM_CLIENTS],
	input  logic [mem_pkg::ADDR_W-1:0] addr_i [arb_pkg::NUM_CLIENTS],
	input  logic [mem_pkg::DATA_W-1:0] wdata_i [arb_pkg::NUM_CLIENTS],
	output logic ack_o [arb_pkg::NUM_CLIENTS],
	output logic [mem_pkg::DATA_W-1:0] rdata_o [arb_pkg::NUM_CLIENTS]
);

	client_if cif0 ();
	client_if cif1 ();
	client_if cif2 ();
	client_if cif3 ();
	ram_if rif ();

	client_port port0 (
		.clk(clk),
		.reset_i(reset_i),
		.req_i(req_i[0]),
		.we_i(we_i[0]),
		.addr_i(addr_i[0]),
		.wdata_i(wdata_i[0]),
		.ack_o(ack_o[0]),
		.rdata_o(rdata_o[0]),
		.cif(cif0)
	);

	client_port port1 (
		.clk(clk),
		.reset_i(reset_i),
		.req_i(req_i[1]),
		.we_i(we_i[1]),
		.addr_i(addr_i[1]),
		.wdata_i(wdata_i[1]),
		.ack_o(ack_o[1]),
		.rdata_o(rdata_o[1]),
		.cif(cif1)
	);

	client_port port2 (
		.clk(clk),
		.reset_i(reset_i),
		.req_i(req_i[2]),
		.we_i(we_i[2]),
		.addr_i(addr_i[2]),
		.wdata_i(wdata_i[2]),
		.ack_o(ack_o[2]),
		.rdata_o(rdata_o[2]),
		.cif(cif2)
	);

	client_port port3 (
		.clk(clk),
		.reset_i(reset_i),
		.req_i(req_i[3]),
		.we_i(we_i[3]),
		.addr_i(addr_i[3]),
		.wdata_i(wdata_i[3]),
		.ack_o(ack_o[3]),
		.rdata_o(rdata_o[3]),
		.cif(cif3)
	);

	mem_scheduler sched0 (
		.clk(clk),
		.reset_i(reset_i),
		.cif0(cif0),
		.cif1(cif1),
		.cif2(cif2),
		.cif3(cif3),
		.rif(rif)
	);

	scratch_ram ram0 (
		.clk(clk),
		.rif(rif)
	);

endmodule

//--- scratch_ram.sv
// Single-port scratch RAM
// Synchronous write, registered read, contents unknown until written

`timescale 1ns/1ns

module scratch_ram (
	input  logic clk,
	ram_if.ram rif
);
	import mem_pkg::*;

	logic [DATA_W-1:0] mem [RAM_DEPTH];
	logic [DATA_W-1:0] rdata_q;

	always_ff @(posedge clk)
	begin
		if (rif.en)
		begin
			if (rif.we)
				mem[rif.addr] <= rif.wdata;
			else
				rdata_q <= mem[rif.addr];
		end
	end

	// Holds the last read until the next one
	assign rif.rdata = rdata_q;

endmodule

//--- mem_scheduler.sv
// Shared RAM scheduler
// Picks one pending client per cycle, issues a registered RAM access with a
// tag, and routes the returning read data to the owner by that tag

`timescale 1ns/1ns

module mem_scheduler (
	input  logic clk,
	input  logic reset_i,
	client_if.sched cif0,
	client_if.sched cif1,
	client_if.sched cif2,
	client_if.sched cif3,
	ram_if.sched rif
);
	import arb_pkg::*;
	import mem_pkg::*;

	logic [NUM_CLIENTS-1:0] pending;
	logic [NUM_CLIENTS-1:0] eligible;
	logic [NUM_CLIENTS-1:0] grant_sel;
	logic [NUM_CLIENTS-1:0] grant_vec;
	logic [NUM_CLIENTS-1:0] done_vec;
	logic issue;
	logic [CLIENT_W-1:0] sel_tag;
	logic sel_we;
	logic [ADDR_W-1:0] sel_addr;
	logic [DATA_W-1:0] sel_wdata;
	logic req_valid;
	logic [CLIENT_W-1:0] req_tag;
	logic req_we;
	logic [ADDR_W-1:0] req_addr;
	logic [DATA_W-1:0] req_wdata;
	logic resp_valid;
	logic [CLIENT_W-1:0] resp_tag;

	////////////////////////////////////////////////////////////////////////////
	// Issue stage
	////////////////////////////////////////////////////////////////////////////

	assign pending = {cif3.pending, cif2.pending, cif1.pending, cif0.pending};

	// The client in issue still shows pending until it sees grant
	assign eligible = pending & ~grant_vec;
	assign issue = |eligible;

	lru_arbiter4 arb0 (
		.clk(clk),
		.reset_i(reset_i),
		.req_i(eligible),
		.update_lru_i(issue),
		.grant_o(grant_sel)
	);

	// Command mux
	always_comb
	begin
		case (grant_sel)
			4'b0010: {sel_tag, sel_we, sel_addr, sel_wdata} = {2'd1, cif1.we, cif1.addr, cif1.wdata};
			4'b0100: {sel_tag, sel_we, sel_addr, sel_wdata} = {2'd2, cif2.we, cif2.addr, cif2.wdata};
			4'b1000: {sel_tag, sel_we, sel_addr, sel_wdata} = {2'd3, cif3.we, cif3.addr, cif3.wdata};
			default: {sel_tag, sel_we, sel_addr, sel_wdata} = {2'd0, cif0.we, cif0.addr, cif0.wdata};
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			req_valid <= 1'b0;
			resp_valid <= 1'b0;
		end
		else
		begin
			req_valid <= issue;
			resp_valid <= req_valid;
		end
	end

	// Request and tag pipeline
	always_ff @(posedge clk)
	begin
		req_tag <= sel_tag;
		req_we <= sel_we;
		req_addr <= sel_addr;
		req_wdata <= sel_wdata;
		resp_tag <= req_tag;
	end

	assign rif.en = req_valid;
	assign rif.we = req_we;
	assign rif.addr = req_addr;
	assign rif.wdata = req_wdata;

	////////////////////////////////////////////////////////////////////////////
	// Response routing
	////////////////////////////////////////////////////////////////////////////

	// Grant while in issue, done while the RAM data returns
	always_comb
	begin
		for (int i = 0; i < NUM_CLIENTS; i++)
		begin
			grant_vec[i] = req_valid && (req_tag == CLIENT_W'(i));
			done_vec[i] = resp_valid && (resp_tag == CLIENT_W'(i));
		end
	end

	assign cif0.grant = grant_vec[0];
	assign cif1.grant = grant_vec[1];
	assign cif2.grant = grant_vec[2];
	assign cif3.grant = grant_vec[3];

	assign cif0.done = done_vec[0];
	assign cif1.done = done_vec[1];
	assign cif2.done = done_vec[2];
	assign cif3.done = done_vec[3];

	// Read data is broadcast, done picks the owner
	assign cif0.rdata = rif.rdata;
	assign cif1.rdata = rif.rdata;
	assign cif2.rdata = rif.rdata;
	assign cif3.rdata = rif.rdata;

endmodule

//--- lru_arbiter4.sv
// Four-way pseudo-LRU tree arbiter
// Two leaf decisions and one top decision, each steered by one LRU bit

`timescale 1ns/1ns

module lru_arbiter4 (
	input  logic clk,
	input  logic reset_i,
	input  logic [arb_pkg::NUM_CLIENTS-1:0] req_i,
	input  logic update_lru_i,
	output logic [arb_pkg::NUM_CLIENTS-1:0] grant_o
);
	import arb_pkg::*;

	// Bit 2 steers the left pair, bit 1 the top, bit 0 the right pair
	logic [LRU_W-1:0] lru_bits;
	logic [LRU_W-1:0] lru_nxt;
	logic [1:0] left_grant;
	logic [1:0] right_grant;
	logic [1:0] top_grant;

	// Two-way decision, prio high favours input 1
	function automatic logic [1:0] arb2(input logic prio, input logic [1:0] req);
		logic [1:0] grant;
		if (prio)
		begin
			grant[1] = req[1];
			grant[0] = req[0] & ~req[1];
		end
		else
		begin
			grant[0] = req[0];
			grant[1] = req[1] & ~req[0];
		end
		return grant;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Grant tree
	////////////////////////////////////////////////////////////////////////////

	assign left_grant = arb2(lru_bits[2], req_i[1:0]);
	assign right_grant = arb2(lru_bits[0], req_i[3:2]);

	// Top picks between halves that have a winner
	assign top_grant = arb2(lru_bits[1], {|right_grant, |left_grant});

	assign grant_o = {right_grant & {2{top_grant[1]}}, left_grant & {2{top_grant[0]}}};

	////////////////////////////////////////////////////////////////////////////
	// LRU update
	////////////////////////////////////////////////////////////////////////////

	// Flip the bits on the winning path toward the other side
	always_comb
	begin
		case (grant_o)
			4'b0001: lru_nxt = {1'b1, 1'b1, lru_bits[0]};
			4'b0010: lru_nxt = {1'b0, 1'b1, lru_bits[0]};
			4'b0100: lru_nxt = {lru_bits[2], 1'b0, 1'b1};
			4'b1000: lru_nxt = {lru_bits[2], 1'b0, 1'b0};
			default: lru_nxt = lru_bits;
		endcase
	end

	// Only a grant that was actually used ages the tree
	always_ff @(posedge clk)
	begin
		if (reset_i)
			lru_bits <= '0;
		else if (update_lru_i && |req_i)
			lru_bits <= lru_nxt;
	end

endmodule

//--- client_port.sv
// Client endpoint for the shared RAM
// Four-phase req/ack on the outside, pending/grant/done toward the scheduler

`timescale 1ns/1ns

module client_port (
	input  logic clk,
	input  logic reset_i,
	input  logic req_i,
	input  logic we_i,
	input  logic [mem_pkg::ADDR_W-1:0] addr_i,
	input  logic [mem_pkg::DATA_W-1:0] wdata_i,
	output logic ack_o,
	output logic [mem_pkg::DATA_W-1:0] rdata_o,
	client_if.port cif
);
	import mem_pkg::*;

	localparam logic [1:0] S_IDLE = 2'd0;
	localparam logic [1:0] S_WAIT = 2'd1;
	localparam logic [1:0] S_ACKED = 2'd2;

	logic [1:0] state;
	logic pending;
	logic cmd_we;
	logic [ADDR_W-1:0] cmd_addr;
	logic [DATA_W-1:0] cmd_wdata;

	// Handshake FSM
	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			state <= S_IDLE;
			pending <= 1'b0;
			ack_o <= 1'b0;
		end
		else
		begin
			case (state)
				S_IDLE:
				begin
					if (req_i)
					begin
						pending <= 1'b1;
						state <= S_WAIT;
					end
				end
				S_WAIT:
				begin
					if (cif.grant)
						pending <= 1'b0;
					// Done always lands after grant
					if (cif.done)
					begin
						ack_o <= 1'b1;
						state <= S_ACKED;
					end
				end
				S_ACKED:
				begin
					// Hold ack until the client lets go of req
					if (!req_i)
					begin
						ack_o <= 1'b0;
						state <= S_IDLE;
					end
				end
				default:
					state <= S_IDLE;
			endcase
		end
	end

	// Command and read data registers
	always_ff @(posedge clk)
	begin
		if (state == S_IDLE && req_i)
		begin
			cmd_we <= we_i;
			cmd_addr <= addr_i;
			cmd_wdata <= wdata_i;
		end
		if (state == S_WAIT && cif.done)
			rdata_o <= cif.rdata;
	end

	assign cif.pending = pending;
	assign cif.we = cmd_we;
	assign cif.addr = cmd_addr;
	assign cif.wdata = cmd_wdata;

endmodule

//--- mem_if.sv
// Interfaces inside the shared RAM design
// client_if: client port to scheduler, one per requester
// ram_if: scheduler to the single-port RAM

`timescale 1ns/1ns

interface client_if;
	import mem_pkg::*;

	// Held command from the port
	logic pending;
	logic we;
	logic [ADDR_W-1:0] addr;
	logic [DATA_W-1:0] wdata;

	// Scheduler pulses, done follows grant by one cycle
	logic grant;
	logic done;
	logic [DATA_W-1:0] rdata;

	modport port (
		output pending, we, addr, wdata,
		input grant, done, rdata
	);

	modport sched (
		input pending, we, addr, wdata,
		output grant, done, rdata
	);
endinterface

interface ram_if;
	import mem_pkg::*;

	logic en;
	logic we;
	logic [ADDR_W-1:0] addr;
	logic [DATA_W-1:0] wdata;
	// Registered, valid the cycle after en
	logic [DATA_W-1:0] rdata;

	modport sched (output en, we, addr, wdata, input rdata);
	modport ram (input en, we, addr, wdata, output rdata);
endinterface

//--- mem_pkg.sv
// Scratch RAM geometry
// Address width, data width and word count

package mem_pkg;

	// Word address into the scratch RAM
	localparam int ADDR_W = 8;

	// Data word
	localparam int DATA_W = 16;

	// Words in the array, fully decoded by ADDR_W
	localparam int RAM_DEPTH = 256;

endpackage

//--- arb_pkg.sv
// Arbitration constants shared by the scheduler and the tree arbiter
// Client count, client tag width, pseudo-LRU tree width

package arb_pkg;

	// Requesters sharing the RAM
	localparam int NUM_CLIENTS = 4;

	// Width of a client index, also used as the response tag
	localparam int CLIENT_W = 2;

	// One priority bit per two-way decision in the tree
	localparam int LRU_W = 3;

endpackage
